// ==== rtl/boot_ram.sv ====
// Boot RAM with byte-strobe writes and registered reads
`timescale 1ns/10ps
`default_nettype none

module boot_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic                         clk_50mhz,
	input  logic                         en,
	input  logic                         we,
	input  logic [$clog2(RAM_WORDS)-1:0] addr,
	input  soc_bus_pkg::data_t           wdata,
	input  soc_bus_pkg::strb_t           wstrb,
	output soc_bus_pkg::data_t           rdata
);

	soc_bus_pkg::data_t mem [RAM_WORDS];

	// rdata only moves on reads so a stalled result stays put
	always_ff @(posedge clk_50mhz) begin
		if (en) begin
			if (we) begin
				for (int i = 0; i < 4; i++)
					if (wstrb[i])
						mem[addr][8*i +: 8] <= wdata[8*i +: 8];
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/bus_router.sv ====
// Address decoder and two-stage dispatch to boot RAM and pad register
`timescale 1ns/10ps
`default_nettype none

module bus_router #(
	parameter int RAM_WORDS = 256
) (
	input  logic                        clk_50mhz,
	input  logic                        resetn,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  logic                        in_write,
	input  soc_bus_pkg::addr_t          in_addr,
	input  soc_bus_pkg::data_t          in_wdata,
	input  soc_bus_pkg::strb_t          in_wstrb,
	input  soc_bus_pkg::pad_buttons_t   pad0_buttons,
	input  soc_bus_pkg::pad_buttons_t   pad1_buttons,
	output logic                        ram_en,
	output logic                        ram_we,
	output logic [$clog2(RAM_WORDS)-1:0] ram_addr,
	output soc_bus_pkg::data_t          ram_wdata,
	output soc_bus_pkg::strb_t          ram_wstrb,
	input  soc_bus_pkg::data_t          ram_rdata,
	output logic                        out_valid,
	input  logic                        out_ready,
	output soc_bus_pkg::data_t          out_rdata,
	output logic                        out_err
);

	localparam int RAM_AW = $clog2(RAM_WORDS);
	localparam int RSB    = soc_map_pkg::RAM_SPAN_BITS;
	localparam int PSB    = soc_map_pkg::PAD_SPAN_BITS;

	logic ram_hit;
	logic pad_hit;
	logic adv;

	// Decode stage
	logic               s1_valid;
	logic               s1_err;
	logic               s1_ram;
	logic               s1_pad;
	logic               s1_write;
	logic [RAM_AW-1:0]  s1_word;
	soc_bus_pkg::data_t s1_wdata;
	soc_bus_pkg::strb_t s1_wstrb;

	// Access stage
	logic               s2_valid;
	logic               s2_err;
	logic               s2_ram_rd;
	soc_bus_pkg::data_t s2_data;

	assign ram_hit = (in_addr[31:RSB] == soc_map_pkg::RAM_BASE[31:RSB]);
	// Pad register is read-only
	assign pad_hit = (in_addr[31:PSB] == soc_map_pkg::PAD_BASE[31:PSB]) && !in_write;

	assign adv      = !s2_valid || out_ready;
	assign in_ready = !s1_valid || adv;

	assign ram_en    = s1_valid && s1_ram && adv;
	assign ram_we    = s1_write;
	assign ram_addr  = s1_word;
	assign ram_wdata = s1_wdata;
	assign ram_wstrb = s1_wstrb;

	assign out_valid = s2_valid;
	assign out_err   = s2_err;
	assign out_rdata = s2_ram_rd ? ram_rdata : s2_data;

	always_ff @(posedge clk_50mhz) begin
		if (in_valid && in_ready) begin
			s1_err   <= !(ram_hit || pad_hit);
			s1_ram   <= ram_hit;
			s1_pad   <= pad_hit;
			s1_write <= in_write;
			s1_word  <= in_addr[RAM_AW+1:2];
			s1_wdata <= in_wdata;
			s1_wstrb <= in_wstrb;
		end
		if (s1_valid && adv) begin
			s2_err    <= s1_err;
			s2_ram_rd <= s1_ram && !s1_write;
			s2_data   <= s1_pad ? {16'b0, pad1_buttons, pad0_buttons} : '0;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (in_ready)
				s1_valid <= in_valid;
			if (adv)
				s2_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pad_reader.sv ====
// Two-pad serial reader with clock divider, latch/shift sequencer and button registers
`timescale 1ns/10ps
`default_nettype none

module pad_reader #(
	parameter int PAD_DIV_BITS = 9
) (
	input  logic                      clk_50mhz,
	input  logic                      resetn,
	output logic                      pad_latch,
	output logic                      pad_clk,
	input  logic                      pad0_data,
	input  logic                      pad1_data,
	output soc_bus_pkg::pad_buttons_t pad0_buttons,
	output soc_bus_pkg::pad_buttons_t pad1_buttons
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LATCH,
		ST_SAMPLE,
		ST_CLOCK
	} pad_state_t;

	pad_state_t                state;
	logic [PAD_DIV_BITS-1:0]   div;
	logic                      tick;
	logic [2:0]                bit_cnt;
	soc_bus_pkg::pad_buttons_t shift0;
	soc_bus_pkg::pad_buttons_t shift1;
	soc_bus_pkg::pad_buttons_t shift0_next;
	soc_bus_pkg::pad_buttons_t shift1_next;

	assign tick = (div == '1);

	assign pad_latch = (state == ST_LATCH);
	assign pad_clk   = (state == ST_CLOCK);

	// Active-low lines enter at the top so the first bit lands in bit 0
	assign shift0_next = {~pad0_data, shift0[7:1]};
	assign shift1_next = {~pad1_data, shift1[7:1]};

	always_ff @(posedge clk_50mhz) begin
		if (tick && state == ST_SAMPLE) begin
			shift0 <= shift0_next;
			shift1 <= shift1_next;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div          <= '0;
			state        <= ST_IDLE;
			bit_cnt      <= '0;
			pad0_buttons <= '0;
			pad1_buttons <= '0;
		end else begin
			div <= div + 1'b1;
			if (tick) begin
				case (state)
					ST_IDLE:  state <= ST_LATCH;
					ST_LATCH: begin
						state   <= ST_SAMPLE;
						bit_cnt <= '0;
					end
					ST_SAMPLE: begin
						if (bit_cnt == 3'd7) begin
							pad0_buttons <= shift0_next;
							pad1_buttons <= shift1_next;
							state        <= ST_LATCH;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							state   <= ST_CLOCK;
						end
					end
					default:  state <= ST_SAMPLE;
				endcase
			end
		end
	end

	// Buttons only move when a new frame starts
	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		!$stable({pad1_buttons, pad0_buttons}) |-> $rose(pad_latch))
		else $error("pad buttons changed outside a frame boundary");

endmodule

`default_nettype wire

// ==== rtl/pad_soc_top.sv ====
// Top level with request intake, router, boot RAM, pad reader and response queue
`timescale 1ns/10ps
`default_nettype none

module pad_soc_top #(
	parameter int REQ_DEPTH    = 4,
	parameter int RSP_CREDITS  = 4,
	parameter int RAM_WORDS    = 256,
	parameter int PAD_DIV_BITS = 9
) (
	input  logic               clk_50mhz,
	input  logic               resetn,
	input  logic               req_valid,
	input  logic               req_write,
	input  soc_bus_pkg::addr_t req_addr,
	input  soc_bus_pkg::data_t req_wdata,
	input  soc_bus_pkg::strb_t req_wstrb,
	output logic               req_credit,
	output logic               rsp_valid,
	output soc_bus_pkg::data_t rsp_rdata,
	output logic               rsp_err,
	input  logic               rsp_credit,
	output logic               pad_latch,
	output logic               pad_clk,
	input  logic               pad0_data,
	input  logic               pad1_data
);

	// Intake to router
	logic               iq_valid;
	logic               iq_ready;
	logic               iq_write;
	soc_bus_pkg::addr_t iq_addr;
	soc_bus_pkg::data_t iq_wdata;
	soc_bus_pkg::strb_t iq_wstrb;

	// Router to boot RAM
	logic                         ram_en;
	logic                         ram_we;
	logic [$clog2(RAM_WORDS)-1:0] ram_addr;
	soc_bus_pkg::data_t           ram_wdata;
	soc_bus_pkg::strb_t           ram_wstrb;
	soc_bus_pkg::data_t           ram_rdata;

	// Router to response queue
	logic               rt_valid;
	logic               rt_ready;
	soc_bus_pkg::data_t rt_rdata;
	logic               rt_err;

	soc_bus_pkg::pad_buttons_t pad0_buttons;
	soc_bus_pkg::pad_buttons_t pad1_buttons;

	req_intake #(
		.REQ_DEPTH(REQ_DEPTH)
	) i_req_intake (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_wstrb(req_wstrb),
		.req_credit(req_credit),
		.out_valid(iq_valid),
		.out_ready(iq_ready),
		.out_write(iq_write),
		.out_addr(iq_addr),
		.out_wdata(iq_wdata),
		.out_wstrb(iq_wstrb)
	);

	bus_router #(
		.RAM_WORDS(RAM_WORDS)
	) i_bus_router (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.in_valid(iq_valid),
		.in_ready(iq_ready),
		.in_write(iq_write),
		.in_addr(iq_addr),
		.in_wdata(iq_wdata),
		.in_wstrb(iq_wstrb),
		.pad0_buttons(pad0_buttons),
		.pad1_buttons(pad1_buttons),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_wstrb(ram_wstrb),
		.ram_rdata(ram_rdata),
		.out_valid(rt_valid),
		.out_ready(rt_ready),
		.out_rdata(rt_rdata),
		.out_err(rt_err)
	);

	boot_ram #(
		.RAM_WORDS(RAM_WORDS)
	) i_boot_ram (
		.clk_50mhz(clk_50mhz),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.wstrb(ram_wstrb),
		.rdata(ram_rdata)
	);

	pad_reader #(
		.PAD_DIV_BITS(PAD_DIV_BITS)
	) i_pad_reader (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.pad_latch(pad_latch),
		.pad_clk(pad_clk),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data),
		.pad0_buttons(pad0_buttons),
		.pad1_buttons(pad1_buttons)
	);

	resp_queue #(
		.RSP_CREDITS(RSP_CREDITS)
	) i_resp_queue (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.in_valid(rt_valid),
		.in_ready(rt_ready),
		.in_rdata(rt_rdata),
		.in_err(rt_err),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.rsp_err(rsp_err),
		.rsp_credit(rsp_credit)
	);

endmodule

`default_nettype wire

// ==== rtl/req_intake.sv ====
// Request intake FIFO with credit return on each pop
`timescale 1ns/10ps
`default_nettype none

module req_intake #(
	parameter int REQ_DEPTH = 4
) (
	input  logic               clk_50mhz,
	input  logic               resetn,
	input  logic               req_valid,
	input  logic               req_write,
	input  soc_bus_pkg::addr_t req_addr,
	input  soc_bus_pkg::data_t req_wdata,
	input  soc_bus_pkg::strb_t req_wstrb,
	output logic               req_credit,
	output logic               out_valid,
	input  logic               out_ready,
	output logic               out_write,
	output soc_bus_pkg::addr_t out_addr,
	output soc_bus_pkg::data_t out_wdata,
	output soc_bus_pkg::strb_t out_wstrb
);

	localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(REQ_DEPTH + 1);

	logic               write_q [REQ_DEPTH];
	soc_bus_pkg::addr_t addr_q  [REQ_DEPTH];
	soc_bus_pkg::data_t wdata_q [REQ_DEPTH];
	soc_bus_pkg::strb_t wstrb_q [REQ_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             pop;
	logic             full;

	assign full       = (count == CNT_W'(REQ_DEPTH));
	assign out_valid  = (count != '0);
	assign pop        = out_valid && out_ready;
	assign req_credit = pop;

	assign out_write = write_q[rd_ptr];
	assign out_addr  = addr_q[rd_ptr];
	assign out_wdata = wdata_q[rd_ptr];
	assign out_wstrb = wstrb_q[rd_ptr];

	always_ff @(posedge clk_50mhz) begin
		if (req_valid) begin
			write_q[wr_ptr] <= req_write;
			addr_q[wr_ptr]  <= req_addr;
			wdata_q[wr_ptr] <= req_wdata;
			wstrb_q[wr_ptr] <= req_wstrb;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (req_valid)
				wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({req_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Master spent a credit it never got back
	assert property (@(posedge clk_50mhz) disable iff (!resetn) !(req_valid && full))
		else $error("request accepted while intake FIFO full");

endmodule

`default_nettype wire

// ==== rtl/resp_queue.sv ====
// Two-entry response FIFO gated by master credits
`timescale 1ns/10ps
`default_nettype none

module resp_queue #(
	parameter int RSP_CREDITS = 4
) (
	input  logic               clk_50mhz,
	input  logic               resetn,
	input  logic               in_valid,
	output logic               in_ready,
	input  soc_bus_pkg::data_t in_rdata,
	input  logic               in_err,
	output logic               rsp_valid,
	output soc_bus_pkg::data_t rsp_rdata,
	output logic               rsp_err,
	input  logic               rsp_credit
);

	localparam int CR_W = $clog2(RSP_CREDITS + 1);

	soc_bus_pkg::data_t rdata_q [2];
	logic               err_q   [2];
	logic               wr_ptr;
	logic               rd_ptr;
	logic [1:0]         count;
	logic [CR_W-1:0]    credits;
	logic               push;

	assign in_ready  = (count != 2'd2);
	assign push      = in_valid && in_ready;
	assign rsp_valid = (count != 2'd0) && (credits != '0);
	assign rsp_rdata = rdata_q[rd_ptr];
	assign rsp_err   = err_q[rd_ptr];

	always_ff @(posedge clk_50mhz) begin
		if (push) begin
			rdata_q[wr_ptr] <= in_rdata;
			err_q[wr_ptr]   <= in_err;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			wr_ptr  <= 1'b0;
			rd_ptr  <= 1'b0;
			count   <= 2'd0;
			credits <= CR_W'(RSP_CREDITS);
		end else begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (rsp_valid)
				rd_ptr <= ~rd_ptr;
			count   <= count + {1'b0, push} - {1'b0, rsp_valid};
			credits <= credits + CR_W'(rsp_credit) - CR_W'(rsp_valid);
		end
	end

	// Master hands back only credits it has used
	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		rsp_credit |-> credits != CR_W'(RSP_CREDITS))
		else $error("response credit returned while all credits held");

endmodule

`default_nettype wire

// ==== rtl/soc_bus_pkg.sv ====
// Bus word, byte strobe and pad button types
`default_nettype none

package soc_bus_pkg;

	// Byte address of one bus access
	typedef logic [31:0] addr_t;

	// Read or write data word
	typedef logic [31:0] data_t;

	// One enable per byte lane
	typedef logic [3:0] strb_t;

	// Eight buttons of one pad, 1 = pressed
	typedef logic [7:0] pad_buttons_t;

endpackage

`default_nettype wire

// ==== rtl/soc_map_pkg.sv ====
// Address map of the boot RAM and game-pad register regions
`default_nettype none

package soc_map_pkg;

	// Boot RAM, 1 KiB window
	parameter soc_bus_pkg::addr_t RAM_BASE = 32'h0201_0000;
	parameter int RAM_SPAN_BITS = 10;

	// Pad register, one word
	parameter soc_bus_pkg::addr_t PAD_BASE = 32'h0200_0200;
	parameter int PAD_SPAN_BITS = 2;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f vlog.f --top-module tb_top -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "all tests passed"

// ==== verification/clk_gen.sv ====
// Testbench clock and reset generator
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_50mhz,
	output logic resetn
);

	initial begin
		clk_50mhz = 1'b0;
		forever #(PERIOD_NS / 2) clk_50mhz = ~clk_50mhz;
	end

	// Release just after an edge, like any other input
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_50mhz);
		#1;
		resetn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
// Testbench top with testdata-driven bus master, pad model and response checks
`timescale 1ns/10ps
`default_nettype none

module tb_top;

	localparam int REQ_DEPTH    = 4;
	localparam int RSP_CREDITS  = 4;
	localparam int RAM_WORDS    = 256;
	localparam int PAD_DIV_BITS = 3;
	localparam int RESET_CYCLES = 8;
	// Latch, 8 samples and 7 shift clocks per frame
	localparam int FRAME_CYCLES = 16 * (2 ** PAD_DIV_BITS);
	localparam int REC_WORDS    = 6;
	localparam int MAX_RECS     = 64;

	logic clk_50mhz;
	logic resetn;

	logic               req_valid;
	logic               req_write;
	soc_bus_pkg::addr_t req_addr;
	soc_bus_pkg::data_t req_wdata;
	soc_bus_pkg::strb_t req_wstrb;
	logic               req_credit;
	logic               rsp_valid;
	soc_bus_pkg::data_t rsp_rdata;
	logic               rsp_err;
	logic               rsp_credit = 1'b0;
	logic               pad_latch;
	logic               pad_clk;
	logic               pad0_data;
	logic               pad1_data;

	// Six words per record: op addr wdata wstrb exp_rdata exp_err
	logic [31:0]        tdata [REC_WORDS * MAX_RECS];
	soc_bus_pkg::data_t exp_rdata_q [$];
	logic               exp_err_q [$];

	soc_bus_pkg::pad_buttons_t pad0_btn;
	soc_bus_pkg::pad_buttons_t pad1_btn;
	logic [7:0]                pad0_sr = 8'hff;
	logic [7:0]                pad1_sr = 8'hff;
	logic                      pad_clk_prev = 1'b0;

	logic [15:0] lfsr = 16'd16;

	int req_sent       = 0;
	int credit_returns = 0;
	int rsp_count      = 0;
	int rsp_returned   = 0;
	int err_resp       = 0;
	int err_main       = 0;
	int cycles         = 0;
	int cycle_limit    = 0;

	clk_gen #(
		.PERIOD_NS(20),
		.RESET_CYCLES(RESET_CYCLES)
	) i_clk_gen (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn)
	);

	pad_soc_top #(
		.REQ_DEPTH(REQ_DEPTH),
		.RSP_CREDITS(RSP_CREDITS),
		.RAM_WORDS(RAM_WORDS),
		.PAD_DIV_BITS(PAD_DIV_BITS)
	) i_dut (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_wstrb(req_wstrb),
		.req_credit(req_credit),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.rsp_err(rsp_err),
		.rsp_credit(rsp_credit),
		.pad_latch(pad_latch),
		.pad_clk(pad_clk),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data)
	);

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic [15:0] s;
		s = state >> 1;
		if (state[0])
			s = s ^ 16'hb400;
		return s;
	endfunction

	task automatic check_rdata(input soc_bus_pkg::data_t got, input soc_bus_pkg::data_t expected,
		input int idx, inout int errs);
		if (got !== expected) begin
			errs++;
			$display("FAILED rsp_rdata response %0d: got %h, expected %h", idx, got, expected);
		end
	endtask

	task automatic check_err(input logic got, input logic expected, input int idx, inout int errs);
		if (got !== expected) begin
			errs++;
			$display("FAILED rsp_err response %0d: got %h, expected %h", idx, got, expected);
		end
	endtask

	// Sends one request once the master holds an intake credit
	task automatic issue_request(input int base);
		while (REQ_DEPTH + credit_returns - req_sent <= 0) begin
			@(posedge clk_50mhz);
			#1;
		end
		req_valid = 1'b1;
		req_write = tdata[base][0];
		req_addr  = tdata[base + 1];
		req_wdata = tdata[base + 2];
		req_wstrb = tdata[base + 3][3:0];
		req_sent++;
		@(posedge clk_50mhz);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic wait_pad_frames(input int frames);
		int   seen;
		logic prev;
		seen = 0;
		prev = pad_latch;
		while (seen < frames) begin
			@(posedge clk_50mhz);
			#1;
			if (pad_latch && !prev)
				seen++;
			prev = pad_latch;
		end
	endtask

	assign pad0_data = pad0_sr[0];
	assign pad1_data = pad1_sr[0];

	// Pad shift registers, active low, loaded on latch and shifted per clock rise
	always @(posedge clk_50mhz) begin
		#1;
		if (pad_latch) begin
			pad0_sr = ~pad0_btn;
			pad1_sr = ~pad1_btn;
		end else if (pad_clk && !pad_clk_prev) begin
			pad0_sr = {1'b1, pad0_sr[7:1]};
			pad1_sr = {1'b1, pad1_sr[7:1]};
		end
		pad_clk_prev = pad_clk;
	end

	always @(posedge clk_50mhz) begin
		if (resetn && req_credit)
			credit_returns++;
	end

	// Response checks and random credit return
	always @(posedge clk_50mhz) begin
		logic take;
		if (resetn) begin
			if (rsp_valid) begin
				if (rsp_count >= RSP_CREDITS + rsp_returned) begin
					err_resp++;
					$display("response %0d was sent while the DUT held no credit", rsp_count);
				end
				if (rsp_count >= req_sent) begin
					err_resp++;
					$display("a response arrived with no request outstanding");
				end else begin
					check_rdata(rsp_rdata, exp_rdata_q[rsp_count], rsp_count, err_resp);
					check_err(rsp_err, exp_err_q[rsp_count], rsp_count, err_resp);
				end
				rsp_count++;
			end
			if (rsp_credit)
				rsp_returned++;
			#1;
			take = lfsr[0];
			lfsr = lfsr_next(lfsr);
			rsp_credit = take && (rsp_count > rsp_returned);
		end
	end

	always @(posedge clk_50mhz) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d responses received",
				cycles, rsp_count, req_sent);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		int n_recs;
		int n_pads;
		int base;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		req_wstrb = '0;
		pad0_btn  = '0;
		pad1_btn  = '0;
		for (int i = 0; i < REC_WORDS * MAX_RECS; i++)
			tdata[i] = 32'hf;
		$readmemh("verification/testdata.txt", tdata);

		n_recs = 0;
		n_pads = 0;
		while (n_recs < MAX_RECS && tdata[n_recs * REC_WORDS] != 32'hf) begin
			base = n_recs * REC_WORDS;
			if (tdata[base] == 32'd2) begin
				n_pads++;
			end else begin
				exp_rdata_q.push_back(tdata[base + 4]);
				exp_err_q.push_back(tdata[base + 5][0]);
			end
			n_recs++;
		end
		if (exp_rdata_q.size() == 0) begin
			err_main++;
			$display("no transactions were found in the testdata file");
		end
		cycle_limit = RESET_CYCLES + 40 * exp_rdata_q.size()
			+ 4 * FRAME_CYCLES * ((n_pads > 0) ? n_pads : 1);

		wait (resetn);
		@(posedge clk_50mhz);
		#1;
		if (rsp_valid || req_credit || pad_latch || pad_clk) begin
			err_main++;
			$display("an output was high right after reset");
		end

		for (int r = 0; r < n_recs; r++) begin
			base = r * REC_WORDS;
			case (tdata[base])
				32'd0, 32'd1: issue_request(base);
				32'd2: begin
					pad1_btn = tdata[base + 2][15:8];
					pad0_btn = tdata[base + 2][7:0];
					wait_pad_frames(2);
				end
				default: begin
					err_main++;
					$display("record %0d has an unknown operation %h", r, tdata[base]);
				end
			endcase
		end

		// Drain, then give stray responses or credits a chance to show up
		while (rsp_count < req_sent || credit_returns < req_sent) begin
			@(posedge clk_50mhz);
			#1;
		end
		repeat (8) @(posedge clk_50mhz);
		#1;
		if (credit_returns != req_sent) begin
			err_main++;
			$display("%0d request credits came back for %0d requests", credit_returns, req_sent);
		end
		if (rsp_count != req_sent) begin
			err_main++;
			$display("%0d responses arrived for %0d requests", rsp_count, req_sent);
		end

		$display("requests %0d, responses %0d, errors: response %0d, other %0d",
			req_sent, rsp_count, err_resp, err_main);
		if (err_resp + err_main == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/testdata.txt ====
// Columns in hex: op addr wdata wstrb exp_rdata exp_err
// op 0 read, 1 write, 2 set pads from wdata (pad1 15:8, pad0 7:0) and wait two frames, f end
1 02010000 deadbeef f 00000000 0
0 02010000 00000000 0 deadbeef 0
1 02010004 11223344 f 00000000 0
1 02010004 aabbccdd 5 00000000 0
0 02010004 00000000 0 11bb33dd 0
1 020103fc 01234567 f 00000000 0
1 020103fc 89abcdef 8 00000000 0
0 020103fc 00000000 0 89234567 0
2 00000000 0000a53c 0 00000000 0
0 02000200 00000000 0 0000a53c 0
0 03000000 00000000 0 00000000 1
1 02000200 12345678 f 00000000 1
0 02010400 00000000 0 00000000 1
1 02010010 a5a5a5a5 f 00000000 0
1 02010014 5a5a5a5a f 00000000 0
0 02010010 00000000 0 a5a5a5a5 0
0 02010014 00000000 0 5a5a5a5a 0
0 02000200 00000000 0 0000a53c 0
0 02010000 00000000 0 deadbeef 0
0 02000204 00000000 0 00000000 1
f 00000000 00000000 0 00000000 0

// ==== vlog.f ====
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/req_intake.sv
rtl/bus_router.sv
rtl/boot_ram.sv
rtl/pad_reader.sv
rtl/resp_queue.sv
rtl/pad_soc_top.sv
verification/clk_gen.sv
verification/tb_top.sv
